//--- Bender.yml
package:
  name: can_rx

sources:
  - include_dirs:
      - .
    files:
      - can_rx_pkg.sv
      - can_bit_timing.sv
      - can_bit_destuffer.sv
      - can_crc15.sv
      - can_frame_receiver.sv
      - can_rx_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - can_rx_checker.sv
      - can_rx_tb.sv

//--- can_bit_destuffer.sv
`timescale 1ns/1ns
`include "can_rx_consts.svh"

module can_bit_destuffer (
    input  logic clk,
    input  logic rst,
    input  logic sample_tick,
    input  logic sampled_bit,
    input  logic stuff_enable,
    output logic bit_valid,
    output logic bit_value,
    output logic stuff_error
);

    localparam logic [2:0] STUFF_LIMIT = 3'(`CAN_STUFF_LIMIT);

    logic [2:0] run_len;   // Equal bits seen so far, stuff bits included
    logic       last_bit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_valid   <= 1'b0;
            bit_value   <= 1'b0;
            stuff_error <= 1'b0;
            run_len     <= 3'd0;
            last_bit    <= 1'b0;
        end else begin
            bit_valid   <= 1'b0;
            stuff_error <= 1'b0;

            if (sample_tick) begin
                if (!stuff_enable) begin
                    // Pass through, history restarts from this bit
                    bit_valid <= 1'b1;
                    bit_value <= sampled_bit;
                    last_bit  <= sampled_bit;
                    run_len   <= 3'd1;
                end else if (run_len == STUFF_LIMIT) begin
                    if (sampled_bit == last_bit) begin
                        stuff_error <= 1'b1; // Sixth equal bit
                    end else begin
                        // Stuff bit is dropped but starts a new run
                        last_bit <= sampled_bit;
                        run_len  <= 3'd1;
                    end
                end else begin
                    bit_valid <= 1'b1;
                    bit_value <= sampled_bit;
                    if (sampled_bit == last_bit) begin
                        run_len <= run_len + 3'd1;
                    end else begin
                        last_bit <= sampled_bit;
                        run_len  <= 3'd1;
                    end
                end
            end
        end
    end

endmodule

//--- can_bit_timing.sv
`timescale 1ns/1ns
`include "can_rx_consts.svh"

module can_bit_timing (
    input  logic clk,
    input  logic rst,
    input  logic rx_raw,
    input  logic bus_idle,
    output logic sample_tick,
    output logic sampled_bit,
    output logic bit_start
);

    localparam int BIT_QUANTA = `CAN_BIT_QUANTA;
    localparam int SAMPLE_Q   = `CAN_SAMPLE_QUANTUM;
    localparam int SJW        = `CAN_SJW;

    logic [3:0] quantum;
    logic [3:0] quantum_next;
    logic       rx_prev;
    logic       sync_edge;
    logic       early;
    logic       late;
    logic       restart;
    logic       skip_start;

    // Only recessive to dominant edges carry timing information
    assign sync_edge = rx_raw & ~rx_prev;

    assign early = (quantum < SJW);               // Edge just after our bit start
    assign late  = (quantum >= BIT_QUANTA - SJW); // Edge just before our bit end

    // Hard sync when idle, otherwise only inside the jump width
    assign restart = sync_edge && (bus_idle || early || late);

    assign quantum_next = (restart || quantum == 4'(BIT_QUANTA - 1)) ? 4'd0
                                                                    : quantum + 4'd1;

    // The bit already started a quantum or two ago
    assign skip_start = restart && early && !bus_idle;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            quantum     <= 4'd0;
            rx_prev     <= 1'b0; // Bus idles recessive
            sample_tick <= 1'b0;
            sampled_bit <= 1'b0;
            bit_start   <= 1'b0;
        end else begin
            quantum <= quantum_next;
            rx_prev <= rx_raw;

            bit_start <= (quantum_next == 4'd0) && !skip_start;

            // A hard sync on the sample quantum would sample the same bit twice
            if (quantum == 4'(SAMPLE_Q) && !restart) begin
                sample_tick <= 1'b1;
                sampled_bit <= rx_raw;
            end else begin
                sample_tick <= 1'b0;
            end
        end
    end

endmodule

//--- can_crc15.sv
`timescale 1ns/1ns
`include "can_rx_consts.svh"

module can_crc15
    import can_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     clear,
    input  logic     step,
    input  logic     data_in,
    output can_crc_t crc
);

    can_crc_t base;
    can_crc_t crc_next;
    logic     feedback;

    // Clear together with step folds the bit into an empty register
    assign base     = clear ? '0 : crc;
    assign feedback = data_in ^ base[`CAN_CRC_WIDTH-1];
    assign crc_next = {base[`CAN_CRC_WIDTH-2:0], 1'b0} ^ (feedback ? `CAN_CRC_POLY : '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc <= '0;
        end else if (step) begin
            crc <= crc_next;
        end else if (clear) begin
            crc <= '0;
        end
    end

endmodule

//--- can_frame_receiver.sv
`timescale 1ns/1ns
`include "can_rx_consts.svh"

module can_frame_receiver
    import can_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      bit_valid,
    input  logic      bit_value,
    input  logic      stuff_error,
    output logic      bus_idle,
    output logic      stuff_enable,
    output logic      ack_request,
    output can_id_t   msg_id,
    output logic      rtr,
    output logic      extended,
    output can_data_t msg_data,
    output can_dlc_t  msg_bytes,
    output logic      msg_valid,
    output logic      frame_error
);

    localparam logic [5:0] EOF_LAST   = 6'(`CAN_EOF_BITS - 1);
    localparam logic [5:0] EOF_VALID  = 6'(`CAN_EOF_BITS - 2);
    localparam logic [5:0] INTER_LAST = 6'(`CAN_INTERMISSION_BITS - 1);
    localparam logic [5:0] DELIM_LAST = 6'(`CAN_ERR_DELIM_BITS - 1);
    localparam can_dlc_t   MAX_BYTES  = 4'(`CAN_MAX_BYTES);

    rx_state_e  state;
    logic [5:0] bit_cnt;    // Position inside the current field
    logic [5:0] data_ptr;
    logic [2:0] dlc_bits;
    can_crc_t   crc_rx;
    can_crc_t   crc_calc;
    can_dlc_t   dlc_full;
    can_dlc_t   dlc_capped;
    logic       sof;
    logic       crc_step;

    // SOF from idle, or dominant in the last intermission bit
    assign sof = bit_valid && bit_value &&
                 (state == st_idle || (state == st_intermission && bit_cnt == INTER_LAST));

    assign crc_step = sof || (bit_valid && state inside {st_base_id, st_rtr_srr, st_ide,
                                                         st_ext_id, st_r1, st_r0, st_dlc,
                                                         st_data});

    assign stuff_enable = state inside {st_base_id, st_rtr_srr, st_ide, st_ext_id, st_r1,
                                        st_r0, st_dlc, st_data, st_crc};

    assign bus_idle = (state == st_idle);

    assign dlc_full   = {dlc_bits, bit_value};
    assign dlc_capped = (dlc_full > MAX_BYTES) ? MAX_BYTES : dlc_full;

    can_crc15 u_crc (
        .clk     (clk),
        .rst     (rst),
        .clear   (sof),
        .step    (crc_step),
        .data_in (bit_value),
        .crc     (crc_calc)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= st_idle;
            bit_cnt     <= 6'd0;
            data_ptr    <= 6'd0;
            ack_request <= 1'b0;
            msg_valid   <= 1'b0;
            frame_error <= 1'b0;
            msg_id      <= '0;
            rtr         <= 1'b0;
            extended    <= 1'b0;
            msg_bytes   <= '0;
        end else begin
            msg_valid   <= 1'b0;
            frame_error <= 1'b0;

            if (stuff_error) begin
                state       <= st_error_flag;
                frame_error <= 1'b1;
            end else if (sof) begin
                state     <= st_base_id;
                bit_cnt   <= 6'd28;
                msg_id    <= '0;
                rtr       <= 1'b0;
                extended  <= 1'b0;
                msg_bytes <= '0;
            end else if (bit_valid) begin
                case (state)
                    st_base_id, st_ext_id: begin
                        msg_id[bit_cnt[4:0]] <= bit_value;
                        bit_cnt <= bit_cnt - 6'd1;
                        if (bit_cnt == 6'd18 || bit_cnt == 6'd0)
                            state <= st_rtr_srr;
                    end
                    st_rtr_srr: begin
                        rtr   <= !bit_value; // Recessive RTR marks a remote frame
                        state <= extended ? st_r1 : st_ide;
                    end
                    st_ide: begin
                        extended <= !bit_value;
                        state    <= bit_value ? st_r0 : st_ext_id;
                    end
                    st_r1: state <= st_r0;
                    st_r0: begin
                        state   <= st_dlc;
                        bit_cnt <= 6'd3;
                    end
                    st_dlc: begin
                        if (bit_cnt == 6'd0) begin
                            msg_bytes <= dlc_capped;
                            data_ptr  <= 6'd63;
                            if (rtr || dlc_capped == '0) begin
                                state   <= st_crc;
                                bit_cnt <= 6'd14;
                            end else begin
                                state   <= st_data;
                                bit_cnt <= {3'(dlc_capped - 4'd1), 3'b111};
                            end
                        end else begin
                            bit_cnt <= bit_cnt - 6'd1;
                        end
                    end
                    st_data: begin
                        data_ptr <= data_ptr - 6'd1;
                        bit_cnt  <= bit_cnt - 6'd1;
                        if (bit_cnt == 6'd0) begin
                            state   <= st_crc;
                            bit_cnt <= 6'd14;
                        end
                    end
                    st_crc: begin
                        if (bit_cnt == 6'd0)
                            state <= st_crc_delim;
                        else
                            bit_cnt <= bit_cnt - 6'd1;
                    end
                    st_crc_delim: begin
                        if (bit_value || crc_rx != crc_calc) begin
                            state       <= st_error_flag;
                            frame_error <= 1'b1;
                        end else begin
                            ack_request <= 1'b1; // Driven during the next bit
                            state       <= st_ack_slot;
                        end
                    end
                    st_ack_slot: begin
                        ack_request <= 1'b0;
                        if (!bit_value) begin
                            state       <= st_error_flag;
                            frame_error <= 1'b1;
                        end else begin
                            state <= st_ack_delim;
                        end
                    end
                    st_ack_delim: begin
                        if (bit_value) begin
                            state       <= st_error_flag;
                            frame_error <= 1'b1;
                        end else begin
                            state   <= st_eof;
                            bit_cnt <= 6'd0;
                        end
                    end
                    st_eof: begin
                        if (bit_cnt == EOF_LAST) begin
                            // Dominant here is an overload, the message stands
                            if (bit_value) begin
                                state <= st_error_flag;
                            end else begin
                                state   <= st_intermission;
                                bit_cnt <= 6'd0;
                            end
                        end else if (bit_value) begin
                            state       <= st_error_flag;
                            frame_error <= 1'b1;
                        end else begin
                            msg_valid <= (bit_cnt == EOF_VALID);
                            bit_cnt   <= bit_cnt + 6'd1;
                        end
                    end
                    st_intermission: begin
                        if (bit_value)
                            state <= st_error_flag; // Overload
                        else if (bit_cnt == INTER_LAST)
                            state <= st_idle;
                        else
                            bit_cnt <= bit_cnt + 6'd1;
                    end
                    st_error_flag: begin
                        if (!bit_value) begin
                            state   <= st_error_delim;
                            bit_cnt <= 6'd1;
                        end
                    end
                    st_error_delim: begin
                        if (bit_value) begin
                            state <= st_error_flag;
                        end else if (bit_cnt == DELIM_LAST) begin
                            state   <= st_intermission;
                            bit_cnt <= 6'd0;
                        end else begin
                            bit_cnt <= bit_cnt + 6'd1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Payload and received CRC
    always_ff @(posedge clk) begin
        if (sof) begin
            msg_data <= '0;
        end else if (bit_valid) begin
            case (state)
                st_dlc:  dlc_bits <= {dlc_bits[1:0], bit_value};
                st_data: msg_data[data_ptr] <= bit_value;
                st_crc:  crc_rx[bit_cnt[3:0]] <= bit_value;
                default: ;
            endcase
        end
    end

endmodule

//--- can_rx.f
+incdir+.
can_rx_pkg.sv
can_bit_timing.sv
can_bit_destuffer.sv
can_crc15.sv
can_frame_receiver.sv
can_rx_top.sv
can_rx_checker.sv
can_rx_tb.sv

//--- can_rx_checker.sv
`timescale 1ns/1ns
`include "can_rx_consts.svh"

module can_rx_checker
    import can_rx_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     bit_start,
    input logic     tx_raw,
    input logic     msg_valid,
    input logic     frame_error,
    input can_dlc_t msg_bytes
);

    int failures = 0;

    // A frame ends one way or the other, never both
    a_valid_or_error: assert property (@(posedge clk) disable iff (rst)
        !(msg_valid && frame_error))
        else begin
            $error("msg_valid and frame_error high in the same cycle");
            failures++;
        end

    // ACK drive moves only on a bit boundary
    a_tx_on_bit_start: assert property (@(posedge clk) disable iff (rst)
        $changed(tx_raw) |-> $past(bit_start))
        else begin
            $error("tx_raw changed away from bit_start");
            failures++;
        end

    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        msg_valid |=> !msg_valid)
        else begin
            $error("msg_valid longer than one cycle");
            failures++;
        end

    a_bytes_capped: assert property (@(posedge clk) disable iff (rst)
        msg_bytes <= can_dlc_t'(`CAN_MAX_BYTES))
        else begin
            $error("msg_bytes above the DLC cap");
            failures++;
        end

endmodule

bind can_rx can_rx_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .bit_start   (bit_start),
    .tx_raw      (tx_raw),
    .msg_valid   (msg_valid),
    .frame_error (frame_error),
    .msg_bytes   (msg_bytes)
);

//--- can_rx_consts.svh
`ifndef CAN_RX_CONSTS_SVH
`define CAN_RX_CONSTS_SVH

// Bit timing in clock quanta
`define CAN_PROP_SEG        3
`define CAN_PHASE_SEG1      4
`define CAN_PHASE_SEG2      4
`define CAN_SJW             2

// One sync quantum plus the three segments
`define CAN_BIT_QUANTA      (1 + `CAN_PROP_SEG + `CAN_PHASE_SEG1 + `CAN_PHASE_SEG2)
`define CAN_SAMPLE_QUANTUM  (1 + `CAN_PROP_SEG + `CAN_PHASE_SEG1)

// CRC-15 generator x^15+x^14+x^10+x^8+x^7+x^4+x^3+1
`define CAN_CRC_WIDTH       15
`define CAN_CRC_POLY        15'h4599

// Equal bits before a stuff bit is inserted
`define CAN_STUFF_LIMIT     5

// Frame trailer lengths
`define CAN_EOF_BITS        7
`define CAN_INTERMISSION_BITS 3
`define CAN_ERR_DELIM_BITS  8

// DLC values above this are read as 8 bytes
`define CAN_MAX_BYTES       8

`endif

//--- can_rx_pkg.sv
package can_rx_pkg;

    `include "can_rx_consts.svh"

    // Base IDs sit in 28:18 with the low bits zero
    typedef logic [28:0] can_id_t;

    // First received data bit lands in the MSB
    typedef logic [`CAN_MAX_BYTES*8-1:0] can_data_t;

    typedef logic [3:0] can_dlc_t;

    typedef logic [`CAN_CRC_WIDTH-1:0] can_crc_t;

    // One state per frame field, advanced once per destuffed bit
    typedef enum logic [4:0] {
        st_idle,
        st_base_id,
        st_rtr_srr,     // SRR on the first pass of an extended frame
        st_ide,
        st_ext_id,
        st_r1,
        st_r0,
        st_dlc,
        st_data,
        st_crc,
        st_crc_delim,
        st_ack_slot,
        st_ack_delim,
        st_eof,
        st_intermission,
        st_error_flag,  // Also entered on overload
        st_error_delim
    } rx_state_e;

endpackage

//--- can_rx_tb.sv
`timescale 1ns/1ns
`include "can_rx_consts.svh"

module can_rx_tb
    import can_rx_pkg::*;
();

    localparam int WAIT_LIMIT  = 4000;  // Clocks, longer than any frame
    localparam int CHK_NONE    = 0;
    localparam int CHK_ACK_ON  = 1;
    localparam int CHK_ACK_OFF = 2;
    localparam int CHK_TX_IDLE = 3;

    logic      clk;
    logic      rst;
    logic      bus_drive;
    logic      rx_raw;
    logic      tx_raw;
    can_id_t   msg_id;
    logic      rtr;
    logic      extended;
    can_data_t msg_data;
    can_dlc_t  msg_bytes;
    logic      msg_valid;
    logic      frame_error;

    logic [31:0] rng_state;
    int          errors;
    int          tests_run;
    int          results_seen;
    logic        raw_bits[$];   // SOF through CRC before stuffing
    logic        line_bits[$];  // Same bits as they appear on the bus

    // Expected outcome per frame, in send order
    logic        exp_error[$];
    can_id_t     exp_id[$];
    logic        exp_rtr[$];
    logic        exp_ext[$];
    can_data_t   exp_data[$];
    can_dlc_t    exp_bytes[$];

    assign rx_raw = bus_drive | tx_raw; // Wired-OR, 1 is dominant

    can_rx dut (
        .clk         (clk),
        .rst         (rst),
        .rx_raw      (rx_raw),
        .tx_raw      (tx_raw),
        .msg_id      (msg_id),
        .rtr         (rtr),
        .extended    (extended),
        .msg_data    (msg_data),
        .msg_bytes   (msg_bytes),
        .msg_valid   (msg_valid),
        .frame_error (frame_error)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Serial CRC-15 over the first n unstuffed bits
    function automatic can_crc_t ref_crc15(input int n);
        can_crc_t c;
        logic     fb;
        c = '0;
        for (int i = 0; i < n; i++) begin
            fb = raw_bits[i] ^ c[14];
            c  = {c[13:0], 1'b0};
            if (fb)
                c = c ^ `CAN_CRC_POLY;
        end
        return c;
    endfunction

    // Opposite bit goes in before a bit that follows five equal ones
    function automatic void stuff_frame();
        int   run;
        logic last;
        run  = 0;
        last = 1'b0;
        line_bits.delete();
        foreach (raw_bits[i]) begin
            if (run == `CAN_STUFF_LIMIT) begin
                last = ~last;
                line_bits.push_back(last);
                run = 1;
            end
            if (run > 0 && raw_bits[i] == last) begin
                run++;
            end else begin
                last = raw_bits[i];
                run  = 1;
            end
            line_bits.push_back(raw_bits[i]);
        end
    endfunction

    function automatic can_data_t keep_bytes(input can_data_t d, input int n);
        can_data_t m;
        m = '0;
        for (int i = 0; i < n * 8; i++)
            m[63 - i] = d[63 - i];
        return m;
    endfunction

    function automatic void build_frame(input can_id_t id, input logic ext, input logic remote,
                                        input can_dlc_t dlc, input can_data_t data,
                                        input int flip_crc);
        int       n_bytes;
        can_crc_t crc;
        raw_bits.delete();
        raw_bits.push_back(1'b1); // SOF
        for (int i = 28; i >= 18; i--)
            raw_bits.push_back(id[i]);
        if (ext) begin
            raw_bits.push_back(1'b0); // SRR
            raw_bits.push_back(1'b0); // IDE recessive marks extended
            for (int i = 17; i >= 0; i--)
                raw_bits.push_back(id[i]);
            raw_bits.push_back(!remote);
            raw_bits.push_back(1'b1); // r1
        end else begin
            raw_bits.push_back(!remote);
            raw_bits.push_back(1'b1);
        end
        raw_bits.push_back(1'b1); // r0
        for (int i = 3; i >= 0; i--)
            raw_bits.push_back(dlc[i]);
        n_bytes = (dlc > `CAN_MAX_BYTES) ? `CAN_MAX_BYTES : int'(dlc);
        if (!remote) begin
            for (int i = 0; i < n_bytes * 8; i++)
                raw_bits.push_back(data[63 - i]);
        end
        crc = ref_crc15(raw_bits.size());
        if (flip_crc >= 0)
            crc[flip_crc] = ~crc[flip_crc];
        for (int i = 14; i >= 0; i--)
            raw_bits.push_back(crc[i]);
        stuff_frame();
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, want);
        errors++;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $finish;
    endtask

    // One bus bit of 12 clocks, line checked near the middle
    task automatic send_bit(input logic b, input int chk);
        @(posedge clk);
        #1;
        bus_drive = b;
        repeat (7) @(posedge clk);
        @(negedge clk);
        if (chk == CHK_ACK_ON && rx_raw !== 1'b1)
            report_mismatch("rx_raw", rx_raw, 1'b1);
        if (chk == CHK_ACK_OFF && rx_raw !== 1'b0)
            report_mismatch("rx_raw", rx_raw, 1'b0);
        if (chk == CHK_TX_IDLE && tx_raw !== 1'b0)
            report_mismatch("tx_raw", tx_raw, 1'b0);
        repeat (4) @(posedge clk);
    endtask

    task automatic send_frame(input logic ack_expected, input int idle_bits);
        foreach (line_bits[i])
            send_bit(line_bits[i], CHK_NONE);
        send_bit(1'b0, CHK_NONE); // CRC delimiter
        send_bit(1'b0, ack_expected ? CHK_ACK_ON : CHK_ACK_OFF);
        send_bit(1'b0, CHK_NONE); // ACK delimiter
        repeat (`CAN_EOF_BITS) send_bit(1'b0, CHK_TX_IDLE);
        repeat (`CAN_INTERMISSION_BITS + idle_bits) send_bit(1'b0, CHK_NONE);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        int waited;
        waited = 0;
        while (results_seen < tests_run && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (results_seen < tests_run)
            abort_run($sformatf("timeout waiting for the result of %s", name));
        else
            $display("[%0t] %s: %s", $time, name, (errors == errors_before) ? "pass" : "fail");
    endtask

    task automatic run_frame(input string name, input can_id_t id, input logic ext,
                             input logic remote, input can_dlc_t dlc, input can_data_t payload,
                             input int flip_crc);
        int errors_before;
        int n_bytes;
        errors_before = errors;
        n_bytes = (dlc > `CAN_MAX_BYTES) ? `CAN_MAX_BYTES : int'(dlc);
        exp_error.push_back(flip_crc >= 0);
        exp_id.push_back(id);
        exp_rtr.push_back(remote);
        exp_ext.push_back(ext);
        exp_data.push_back(remote ? '0 : keep_bytes(payload, n_bytes));
        exp_bytes.push_back(can_dlc_t'(n_bytes));
        tests_run++;
        build_frame(id, ext, remote, dlc, payload, flip_crc);
        send_frame(flip_crc < 0, 2);
        finish_test(name, errors_before);
    endtask

    // SOF, two ID bits, then six recessive bits in a row
    task automatic run_stuff_error(input string name);
        int errors_before;
        errors_before = errors;
        exp_error.push_back(1'b1);
        exp_id.push_back('0);
        exp_rtr.push_back(1'b0);
        exp_ext.push_back(1'b0);
        exp_data.push_back('0);
        exp_bytes.push_back('0);
        tests_run++;
        send_bit(1'b1, CHK_NONE);
        send_bit(1'b0, CHK_NONE);
        send_bit(1'b1, CHK_NONE);
        repeat (6) send_bit(1'b0, CHK_NONE);
        repeat (11) send_bit(1'b0, CHK_NONE); // Error delimiter and intermission
        finish_test(name, errors_before);
    endtask

    task automatic compare_result();
        logic      want_err;
        can_id_t   want_id;
        logic      want_rtr;
        logic      want_ext;
        can_data_t want_data;
        can_dlc_t  want_bytes;
        want_err   = exp_error.pop_front();
        want_id    = exp_id.pop_front();
        want_rtr   = exp_rtr.pop_front();
        want_ext   = exp_ext.pop_front();
        want_data  = exp_data.pop_front();
        want_bytes = exp_bytes.pop_front();
        if (want_err && !frame_error) begin
            $display("msg_valid at %0t ns where a frame error was expected", $time);
            errors++;
        end else if (!want_err && !msg_valid) begin
            $display("frame_error at %0t ns where a valid message was expected", $time);
            errors++;
        end else if (!want_err) begin
            if (msg_id !== want_id)
                report_mismatch("msg_id", msg_id, want_id);
            if (rtr !== want_rtr)
                report_mismatch("rtr", rtr, want_rtr);
            if (extended !== want_ext)
                report_mismatch("extended", extended, want_ext);
            if (msg_bytes !== want_bytes)
                report_mismatch("msg_bytes", msg_bytes, want_bytes);
            if (msg_data !== want_data)
                report_mismatch("msg_data", msg_data, want_data);
        end
        results_seen++;
    endtask

    initial begin : compare
        int waited;
        forever begin
            if (exp_error.size() == 0) begin
                @(negedge clk);
                if (msg_valid || frame_error) begin
                    $display("unexpected msg_valid or frame_error at %0t ns", $time);
                    errors++;
                end
            end else begin
                waited = 0;
                do begin
                    @(negedge clk);
                    waited++;
                end while (!(msg_valid || frame_error) && waited < WAIT_LIMIT);
                if (!(msg_valid || frame_error))
                    abort_run("timeout waiting for msg_valid or frame_error");
                else
                    compare_result();
            end
        end
    end

    initial begin : stimulus
        can_id_t   id;
        can_data_t payload;
        can_dlc_t  dlc;
        clk          = 1'b0;
        rst          = 1'b1;
        bus_drive    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        results_seen = 0;
        rng_state    = 32'ha902;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) send_bit(1'b0, CHK_NONE);

        for (int i = 0; i < 6; i++) begin
            id = '0;
            rng_state = lcg_next(rng_state);
            id[28:18] = rng_state[30:20];
            dlc = can_dlc_t'(rng_state[15:8] % 9);
            rng_state = lcg_next(rng_state);
            payload[63:32] = rng_state;
            rng_state = lcg_next(rng_state);
            payload[31:0] = rng_state;
            run_frame($sformatf("base data %0d", i), id, 1'b0, 1'b0, dlc, payload, -1);
        end

        for (int i = 0; i < 2; i++) begin
            rng_state = lcg_next(rng_state);
            id = rng_state[31:3];
            dlc = can_dlc_t'(rng_state[2:0]);
            run_frame($sformatf("extended remote %0d", i), id, 1'b1, 1'b1, dlc, '0, -1);
        end

        rng_state = lcg_next(rng_state);
        id = rng_state[31:3];
        payload = {rng_state, ~rng_state};
        run_frame("extended data", id, 1'b1, 1'b0, 4'd5, payload, -1);

        // DLC above 8 still carries 8 bytes
        rng_state = lcg_next(rng_state);
        id = '0;
        id[28:18] = rng_state[26:16];
        payload = {rng_state, lcg_next(rng_state)};
        run_frame("dlc 12", id, 1'b0, 1'b0, 4'd12, payload, -1);

        rng_state = lcg_next(rng_state);
        id = '0;
        id[28:18] = rng_state[30:20];
        payload = {lcg_next(rng_state), rng_state};
        run_frame("crc bit flipped", id, 1'b0, 1'b0, 4'd3, payload, rng_state[19:16] % 15);

        run_stuff_error("stuff error in id");
        rng_state = lcg_next(rng_state);
        id = '0;
        id[28:18] = rng_state[30:20];
        payload = {rng_state, rng_state ^ 32'h5a5a_a5a5};
        run_frame("frame after stuff error", id, 1'b0, 1'b0, 4'd8, payload, -1);

        errors += dut.u_checker.failures;
        $display("%0d tests, %0d results, %0d errors", tests_run, results_seen, errors);
        if (errors == 0 && results_seen == tests_run)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- can_rx_top.sv
`timescale 1ns/1ns

module can_rx
    import can_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rx_raw,
    output logic      tx_raw,
    output can_id_t   msg_id,
    output logic      rtr,
    output logic      extended,
    output can_data_t msg_data,
    output can_dlc_t  msg_bytes,
    output logic      msg_valid,
    output logic      frame_error
);

    logic sample_tick;
    logic sampled_bit;
    logic bit_start;
    logic bus_idle;
    logic bit_valid;
    logic bit_value;
    logic stuff_error;
    logic stuff_enable;
    logic ack_request;

    can_bit_timing u_timing (
        .clk         (clk),
        .rst         (rst),
        .rx_raw      (rx_raw),
        .bus_idle    (bus_idle),
        .sample_tick (sample_tick),
        .sampled_bit (sampled_bit),
        .bit_start   (bit_start)
    );

    can_bit_destuffer u_destuff (
        .clk          (clk),
        .rst          (rst),
        .sample_tick  (sample_tick),
        .sampled_bit  (sampled_bit),
        .stuff_enable (stuff_enable),
        .bit_valid    (bit_valid),
        .bit_value    (bit_value),
        .stuff_error  (stuff_error)
    );

    can_frame_receiver u_receiver (
        .clk          (clk),
        .rst          (rst),
        .bit_valid    (bit_valid),
        .bit_value    (bit_value),
        .stuff_error  (stuff_error),
        .bus_idle     (bus_idle),
        .stuff_enable (stuff_enable),
        .ack_request  (ack_request),
        .msg_id       (msg_id),
        .rtr          (rtr),
        .extended     (extended),
        .msg_data     (msg_data),
        .msg_bytes    (msg_bytes),
        .msg_valid    (msg_valid),
        .frame_error  (frame_error)
    );

    // ACK drive changes only at a bit boundary so it spans the whole slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            tx_raw <= 1'b0;
        else if (bit_start)
            tx_raw <= ack_request;
    end

endmodule
